//--- filelist.f
verilog/hilbertPkg.sv
verilog/hilbertCoeffRom.sv
verilog/firFilter.sv
verilog/hilbertTransform.sv
verilog/analyticTop.sv
verification/analyticChecker.sv
verification/analyticTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and checks the log for the result.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module analyticTb -f filelist.f -o analyticSim
./obj_dir/analyticSim > sim.log
cat sim.log
if grep -qx "Verification passed" sim.log; then
	exit 0
fi
echo "Simulation did not report success"
exit 1

//--- verification/analyticChecker.sv
`default_nettype none

module analyticChecker #(
	parameter int LENGTH = 27
) (
	input logic clock,
	input logic reset,
	input logic running,
	input logic stop,
	input hilbertPkg::sampleStream_t sampleIn,
	input hilbertPkg::analyticSample_t analyticOut,
	output int valueErrors,
	output int missingErrors,
	output int extraErrors,
	output int pendingCount
);

	localparam int sw = hilbertPkg::sampleWidth;
	localparam int outW = hilbertPkg::outWidth;

	// The filter uses the middle LENGTH entries of the table.
	localparam int firstEntry = (hilbertPkg::maxLength - LENGTH) / 2;
	localparam int centreLag = (LENGTH - 1) / 2;

	// One expected result and the negedge count at which it must show up.
	typedef struct packed {
		int due;
		logic signed [outW-1:0] re;
		logic signed [outW-1:0] im;
	} expected_t;

	// Reference history. Entry 0 is the newest accepted sample.
	logic signed [sw-1:0] history [LENGTH];
	expected_t expectedQueue [$];
	int cycle;

	// The first coefficient loaded ends at the oldest tap, so lag k uses the entry
	// LENGTH-1-k places into the centred window.
	function automatic logic signed [sw-1:0] coeffForLag(input int lag);
		return hilbertPkg::coeffTable[firstEntry + LENGTH - 1 - lag];
	endfunction

	task automatic clearModel();
		for (int lag = 0; lag < LENGTH; lag++) begin
			history[lag] = '0;
		end
	endtask

	task automatic compareField(input string name, input logic [outW-1:0] expected,
			input logic [outW-1:0] actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
		end
	endtask

	// A sample seen here is captured on the next edge and leaves the output register
	// three edges after that, so it is observed four negedges later.
	task automatic acceptSample();
		expected_t entry;
		logic signed [outW-1:0] sum;
		for (int lag = LENGTH - 1; lag > 0; lag--) begin
			history[lag] = history[lag - 1];
		end
		history[0] = sampleIn.data;
		sum = '0;
		for (int lag = 0; lag < LENGTH; lag++) begin
			sum = sum + outW'(coeffForLag(lag)) * outW'(history[lag]);
		end
		entry.due = cycle + 4;
		entry.im = sum;
		// The centre sample is scaled into Q1.17 like the coefficients.
		entry.re = outW'(history[centreLag]) << (sw - 1);
		expectedQueue.push_back(entry);
	endtask

	task automatic checkOutput();
		expected_t front;
		if (expectedQueue.size() > 0 && expectedQueue[0].due == cycle) begin
			front = expectedQueue.pop_front();
			if (!analyticOut.valid) begin
				missingErrors++;
				$display("Missing output: a result was due at %0t but none appeared", $time);
			end else begin
				compareField("analyticOut.re", front.re, analyticOut.re);
				compareField("analyticOut.im", front.im, analyticOut.im);
			end
		end else if (analyticOut.valid) begin
			extraErrors++;
			$display("Unexpected output: analyticOut.valid was high at %0t with no result due",
				$time);
		end else begin
			// Idle cycles must read as all zero.
			compareField("analyticOut.re", '0, analyticOut.re);
			compareField("analyticOut.im", '0, analyticOut.im);
		end
	endtask

	initial begin
		valueErrors = 0;
		missingErrors = 0;
		extraErrors = 0;
		pendingCount = 0;
		cycle = 0;
		clearModel();
	end

	// Everything is sampled half a cycle away from the edges where it changes.
	// A stop or a reset drops whatever the pipeline still holds.
	always @(negedge clock) begin
		checkOutput();
		if (reset) begin
			expectedQueue.delete();
			clearModel();
		end else if (running) begin
			if (sampleIn.valid) begin
				acceptSample();
			end
			if (stop) begin
				expectedQueue.delete();
			end
		end else begin
			clearModel();
		end
		cycle++;
		pendingCount = expectedQueue.size();
	end

endmodule

`default_nettype wire

//--- verification/analyticTb.sv
`default_nettype none

module analyticTb;

	localparam int LENGTH = 27;
	localparam int clockPeriod = 20;
	localparam int resetCycles = 5;
	localparam int phaseCount = 18;
	localparam int sw = hilbertPkg::sampleWidth;

	typedef enum logic [2:0] {actStart, actStream, actStop, actIdle, actReset} action_e;
	typedef enum logic [2:0] {
		patImpulse, patStep, patRamp, patRandom, patAlternate, patZero
	} pattern_e;

	// One row of the stimulus table. The gap rate is a percentage of idle cycles.
	typedef struct packed {
		action_e action;
		logic [15:0] count;
		pattern_e pattern;
		logic [6:0] gapRate;
	} phase_t;

	// The clock starts low before any process runs, so time zero has no falling edge.
	logic clock = 1'b0;
	logic reset;
	logic enable;
	logic stop;
	logic running;
	logic tableReady;
	hilbertPkg::sampleStream_t sampleIn;
	hilbertPkg::analyticSample_t analyticOut;
	int valueErrors;
	int missingErrors;
	int extraErrors;
	int pendingCount;
	int controlErrors;
	longint watchdogLimit;
	phase_t phaseTable [phaseCount];

	analyticTop #(
		.LENGTH(LENGTH)
	) DUT (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.stop(stop),
		.sampleIn(sampleIn),
		.analyticOut(analyticOut),
		.running(running)
	);

	analyticChecker #(
		.LENGTH(LENGTH)
	) outputChecker (
		.clock(clock),
		.reset(reset),
		.running(running),
		.stop(stop),
		.sampleIn(sampleIn),
		.analyticOut(analyticOut),
		.valueErrors(valueErrors),
		.missingErrors(missingErrors),
		.extraErrors(extraErrors),
		.pendingCount(pendingCount)
	);

	initial begin
		forever begin
			#(clockPeriod / 2) clock = ~clock;
		end
	end

	// Full-scale alternation uses the largest and the most negative codes.
	function automatic logic signed [sw-1:0] sampleFor(input pattern_e pattern, input int index);
		case (pattern)
			patImpulse: return (index == 0) ? sw'(1) : '0;
			patStep: return 18'h1FFFF;
			patRamp: return sw'(index * 2731 - 65536);
			patRandom: return sw'($urandom);
			patAlternate: return index[0] ? 18'h20000 : 18'h1FFFF;
			default: return '0;
		endcase
	endfunction

	// Every input changes one time unit after a rising edge.
	task automatic nextCycle();
		@(posedge clock);
		#1;
	endtask

	task automatic expectIdle(input string where);
		if (running || analyticOut.valid) begin
			controlErrors++;
			$display("running or analyticOut.valid is still high %s at %0t", where, $time);
		end
	endtask

	task automatic startRun();
		int cycles;
		cycles = 0;
		nextCycle();
		enable = 1'b1;
		sampleIn = '0;
		while (!running && cycles < LENGTH + 10) begin
			nextCycle();
			cycles++;
		end
		if (!running) begin
			controlErrors++;
			$display("running never rose after enable was raised");
		end else if (cycles != LENGTH + 2) begin
			controlErrors++;
			$display("running rose %0d cycles after enable, not %0d", cycles, LENGTH + 2);
		end
	endtask

	// Gap cycles carry random data with valid low, which must not enter the history.
	task automatic streamSamples(input int count, input pattern_e pattern, input int gapRate);
		int sent;
		sent = 0;
		while (sent < count) begin
			nextCycle();
			if (($urandom % 100) < gapRate) begin
				sampleIn.valid = 1'b0;
				sampleIn.data = sw'($urandom);
			end else begin
				sampleIn.valid = 1'b1;
				sampleIn.data = sampleFor(pattern, sent);
				sent++;
			end
		end
	endtask

	// Stop arrives together with a live sample, then enable drops so the FSM can idle.
	// Samples keep coming and must all be ignored.
	task automatic stopRun(input int count);
		nextCycle();
		stop = 1'b1;
		sampleIn = {1'b1, sw'($urandom)};
		nextCycle();
		if (running) begin
			controlErrors++;
			$display("running stayed high after stop at %0t", $time);
		end
		stop = 1'b0;
		enable = 1'b0;
		for (int i = 0; i < count; i++) begin
			nextCycle();
			sampleIn = {1'b1, sw'($urandom)};
			expectIdle("after stop");
		end
	endtask

	task automatic idleCycles(input int count, input pattern_e pattern);
		enable = 1'b0;
		for (int i = 0; i < count; i++) begin
			nextCycle();
			sampleIn = {1'b1, sampleFor(pattern, i)};
		end
		nextCycle();
		sampleIn = '0;
	endtask

	task automatic resetDuringRun(input int count);
		for (int i = 0; i < count; i++) begin
			nextCycle();
			reset = 1'b1;
			enable = 1'b0;
			sampleIn = {1'b1, sw'($urandom)};
		end
		nextCycle();
		reset = 1'b0;
		sampleIn = '0;
		expectIdle("after reset");
		nextCycle();
		expectIdle("one cycle after reset");
	endtask

	task automatic applyPhase(input phase_t phase);
		case (phase.action)
			actStart: startRun();
			actStream: begin
				streamSamples(int'(phase.count), phase.pattern, int'(phase.gapRate));
			end
			actStop: stopRun(int'(phase.count));
			actIdle: idleCycles(int'(phase.count), phase.pattern);
			default: resetDuringRun(int'(phase.count));
		endcase
	endtask

	// The impulse rows start from a cleared history, so im shows the taps directly.
	task automatic buildTable();
		phaseTable[0] = '{actStart, 16'd0, patZero, 7'd0};
		phaseTable[1] = '{actStream, 16'd40, patImpulse, 7'd0};
		phaseTable[2] = '{actStream, 16'd200, patRandom, 7'd0};
		phaseTable[3] = '{actStream, 16'd200, patRandom, 7'd30};
		phaseTable[4] = '{actStream, 16'd64, patAlternate, 7'd0};
		phaseTable[5] = '{actStream, 16'd64, patStep, 7'd0};
		phaseTable[6] = '{actStream, 16'd40, patRamp, 7'd10};
		phaseTable[7] = '{actStream, 16'd30, patRandom, 7'd0};
		phaseTable[8] = '{actStop, 16'd8, patRandom, 7'd0};
		phaseTable[9] = '{actIdle, 16'd10, patRandom, 7'd0};
		phaseTable[10] = '{actStart, 16'd0, patZero, 7'd0};
		phaseTable[11] = '{actStream, 16'd40, patImpulse, 7'd0};
		phaseTable[12] = '{actStream, 16'd60, patRandom, 7'd20};
		phaseTable[13] = '{actReset, 16'd5, patRandom, 7'd0};
		phaseTable[14] = '{actStart, 16'd0, patZero, 7'd0};
		phaseTable[15] = '{actStream, 16'd80, patRandom, 7'd15};
		phaseTable[16] = '{actStop, 16'd4, patRandom, 7'd0};
		phaseTable[17] = '{actIdle, 16'd6, patZero, 7'd0};
	endtask

	initial begin
		int seedValue;
		longint budget;
		int totalErrors;
		tableReady = 1'b0;
		seedValue = $urandom(32'h9246_65b0);
		controlErrors = 0;
		reset = 1'b1;
		enable = 1'b0;
		stop = 1'b0;
		sampleIn = '0;
		buildTable();
		budget = resetCycles + 20;
		for (int i = 0; i < phaseCount; i++) begin
			budget += int'(phaseTable[i].count) * 2 + LENGTH + 20;
		end
		watchdogLimit = budget * clockPeriod;
		tableReady = 1'b1;
		repeat (resetCycles) @(posedge clock);
		#1;
		reset = 1'b0;
		for (int i = 0; i < phaseCount; i++) begin
			applyPhase(phaseTable[i]);
		end
		repeat (10) nextCycle();
		if (pendingCount != 0) begin
			controlErrors++;
			$display("%0d expected results never appeared", pendingCount);
		end
		totalErrors = valueErrors + missingErrors + extraErrors + controlErrors;
		$display("Errors: value %0d, missing %0d, extra %0d, control %0d",
			valueErrors, missingErrors, extraErrors, controlErrors);
		if (totalErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// The limit allows two cycles per sample plus a load and some slack for every row.
	initial begin
		wait (tableReady);
		#(watchdogLimit);
		$display("Timeout: the run did not finish within %0d time units", watchdogLimit);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/analyticTop.sv
`default_nettype none

module analyticTop #(
	// Number of filter taps. It must be odd and no more than the table holds.
	parameter int LENGTH = 27
) (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic stop,
	input hilbertPkg::sampleStream_t sampleIn,
	output hilbertPkg::analyticSample_t analyticOut,
	output logic running
);

	// The whole transformer sits under one controller.
	// Here the tap count is fixed and passed down.
	hilbertTransform #(
		.LENGTH(LENGTH)
	) transform (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.stop(stop),
		.sampleIn(sampleIn),
		.analyticOut(analyticOut),
		.running(running)
	);

endmodule

`default_nettype wire

//--- verilog/firFilter.sv
`default_nettype none

module firFilter #(
	parameter int LENGTH = 27
) (
	input logic clock,
	input logic reset,
	input hilbertPkg::coeffBeat_t coeffBeat,
	input logic clearHistory,
	input hilbertPkg::sampleStream_t firIn,
	output hilbertPkg::analyticSample_t firOut
);

	// The middle tap. Its lag is the group delay of the filter.
	localparam int centreTap = (LENGTH - 1) / 2;

	// A full product of a sample and a coefficient.
	localparam int productWidth = 2 * hilbertPkg::sampleWidth;

	// Coefficient chain. Tap 0 weights the newest sample.
	logic signed [hilbertPkg::sampleWidth-1:0] coeffChain [LENGTH];

	// Sample history. Entry 0 is the newest accepted sample.
	logic signed [hilbertPkg::sampleWidth-1:0] delayLine [LENGTH];

	// Registered products, one per tap.
	logic signed [productWidth-1:0] product [LENGTH];

	// Middle sample, held alongside the products.
	logic signed [hilbertPkg::sampleWidth-1:0] centreStage;

	// Middle sample widened to the output format before the shift.
	logic signed [hilbertPkg::outWidth-1:0] centreWide;

	// Sum of all products for the sample now in the product stage.
	logic signed [hilbertPkg::outWidth-1:0] tapSum;

	// Valid bits that follow a sample through the delay line and the product stage.
	logic sampleValid;
	logic productValid;

	// Each beat enters at tap 0 and pushes the earlier ones up.
	// After a full load the first beat sits at tap LENGTH-1 and the last at tap 0.
	// The ROM streams the table upward, so tap i ends up holding the entry for
	// lag i minus centreTap, which gives the usual 2/(pi*n) response.
	always_ff @(posedge clock) begin
		if (coeffBeat.valid) begin
			coeffChain[0] <= coeffBeat.value;
			for (int i = 1; i < LENGTH; i++) begin
				coeffChain[i] <= coeffChain[i - 1];
			end
		end
	end

	// The history moves only on accepted samples, so a gap in the stream leaves it alone.
	// It is held at zero while the controller is idle.
	always_ff @(posedge clock) begin
		if (reset || clearHistory) begin
			for (int i = 0; i < LENGTH; i++) begin
				delayLine[i] <= '0;
			end
		end else if (firIn.valid) begin
			delayLine[0] <= firIn.data;
			for (int i = 1; i < LENGTH; i++) begin
				delayLine[i] <= delayLine[i - 1];
			end
		end
	end

	// A sample written at edge t reaches the products at t+1 and the output at t+2.
	always_ff @(posedge clock) begin
		if (reset) begin
			sampleValid <= 1'b0;
			productValid <= 1'b0;
		end else begin
			sampleValid <= firIn.valid;
			productValid <= sampleValid;
		end
	end

	// The Hilbert taps vanish at even lags from the centre, the centre included.
	// Those products stay at zero, so only about half the taps need a multiplier.
	// The middle sample is captured in the same cycle to keep the two paths aligned.
	always_ff @(posedge clock) begin
		for (int i = 0; i < LENGTH; i++) begin
			if (((i - centreTap) % 2) == 0) begin
				product[i] <= '0;
			end else begin
				product[i] <= coeffChain[i] * delayLine[i];
			end
		end
		centreStage <= delayLine[centreTap];
	end

	// Adder tree over every tap. Each product is sign-extended to the output width.
	always_comb begin
		tapSum = '0;
		for (int i = 0; i < LENGTH; i++) begin
			tapSum = tapSum + product[i];
		end
	end

	// Sign extension of the centre sample.
	assign centreWide = centreStage;

	// Second stage. The sum goes out as im.
	// The centre sample goes out as re, shifted into Q1.17 like the coefficients.
	always_ff @(posedge clock) begin
		if (reset) begin
			firOut.valid <= 1'b0;
		end else begin
			firOut.valid <= productValid;
		end
		firOut.im <= tapSum;
		firOut.re <= centreWide << (hilbertPkg::sampleWidth - 1);
	end

endmodule

`default_nettype wire

//--- verilog/hilbertCoeffRom.sv
`default_nettype none

module hilbertCoeffRom #(
	parameter int LENGTH = 27
) (
	input logic clock,
	input logic reset,
	input logic romStart,
	output hilbertPkg::coeffBeat_t coeffBeat
);

	// The filter uses the LENGTH entries in the middle of the table.
	// So the walk starts this far from entry 0.
	localparam int firstEntry = (hilbertPkg::maxLength - LENGTH) / 2;

	// Enough bits to count every entry of the table.
	localparam int indexWidth = $clog2(hilbertPkg::maxLength);

	// Offset of the current beat within the centred window.
	logic [indexWidth-1:0] index;

	// High while a load is streaming out.
	logic active;

	// Marks the beat that closes the window.
	logic finalBeat;

	assign finalBeat = active && (index == indexWidth'(LENGTH - 1));

	// The counter starts on romStart and stops by itself after LENGTH beats.
	// A second request in the middle of a load starts over from the first entry.
	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			index <= '0;
		end else if (romStart) begin
			active <= 1'b1;
			index <= '0;
		end else if (active) begin
			if (finalBeat) begin
				active <= 1'b0;
				index <= '0;
			end else begin
				index <= index + 1'b1;
			end
		end
	end

	// Beats come straight from the counter, so the first one shows up the
	// cycle after romStart is seen.
	// Between loads every field stays at zero.
	always_comb begin
		coeffBeat = '0;
		if (active) begin
			coeffBeat.valid = 1'b1;
			coeffBeat.last = finalBeat;
			coeffBeat.value = hilbertPkg::coeffTable[firstEntry + int'(index)];
		end
	end

endmodule

`default_nettype wire

//--- verilog/hilbertPkg.sv
`default_nettype none

package hilbertPkg;

	// Width of one input sample. The coefficients use the same width in Q1.17.
	localparam int sampleWidth = 18;

	// Output width. A full product plus the growth of the tap sum fits with room to spare.
	localparam int outWidth = 3 * sampleWidth;

	// Entries in the coefficient table, which is also the longest filter supported.
	localparam int maxLength = 31;

	// Hilbert taps in Q1.17, centred on entry 15.
	// Entry 15-k holds 2/(pi*k) times a 31-point Hamming window for odd k.
	// Entry 15+k holds the negative of entry 15-k, and every even offset is zero.
	localparam logic signed [sampleWidth-1:0] coeffTable [0:maxLength-1] = '{
		18'sd445, 18'sd0, 18'sd769, 18'sd0, 18'sd1761, 18'sd0, 18'sd3689, 18'sd0,
		18'sd7010, 18'sd0, 18'sd12850, 18'sd0, 18'sd25371, 18'sd0, 18'sd82604,
		18'sd0,
		-18'sd82604, 18'sd0, -18'sd25371, 18'sd0, -18'sd12850, 18'sd0, -18'sd7010,
		18'sd0, -18'sd3689, 18'sd0, -18'sd1761, 18'sd0, -18'sd769, 18'sd0, -18'sd445
	};

	// One input sample, qualified by valid.
	typedef struct packed {
		logic valid;
		logic signed [sampleWidth-1:0] data;
	} sampleStream_t;

	// One coefficient on its way from the ROM into the filter chain.
	typedef struct packed {
		logic valid;
		logic last;
		logic signed [sampleWidth-1:0] value;
	} coeffBeat_t;

	// The analytic pair. Both halves carry the same Q1.17 scaling.
	typedef struct packed {
		logic valid;
		logic signed [outWidth-1:0] re;
		logic signed [outWidth-1:0] im;
	} analyticSample_t;

	// Controller states, in the order a run goes through them.
	typedef enum logic [1:0] {
		stateIdle,
		stateLoad,
		stateRun,
		stateStop
	} hilbertState_e;

endpackage

`default_nettype wire

//--- verilog/hilbertTransform.sv
`default_nettype none

module hilbertTransform #(
	parameter int LENGTH = 27
) (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic stop,
	input hilbertPkg::sampleStream_t sampleIn,
	output hilbertPkg::analyticSample_t analyticOut,
	output logic running
);

	// Current controller state.
	hilbertPkg::hilbertState_e state;

	// One-cycle request that starts the coefficient stream.
	logic romStart;

	// Coefficient beats. The filter takes them and the FSM watches for the last one.
	hilbertPkg::coeffBeat_t coeffBeat;

	// Samples gated by the state, and the filter's result.
	hilbertPkg::sampleStream_t firIn;
	hilbertPkg::analyticSample_t firOut;

	// Holds the filter history at zero between runs.
	logic clearHistory;

	// High when the FSM stays in RUN across the coming edge.
	logic keepRunning;

	hilbertCoeffRom #(
		.LENGTH(LENGTH)
	) coeffRom (
		.clock(clock),
		.reset(reset),
		.romStart(romStart),
		.coeffBeat(coeffBeat)
	);

	firFilter #(
		.LENGTH(LENGTH)
	) filter (
		.clock(clock),
		.reset(reset),
		.coeffBeat(coeffBeat),
		.clearHistory(clearHistory),
		.firIn(firIn),
		.firOut(firOut)
	);

	// IDLE waits for enable and asks the ROM for the taps.
	// LOAD lasts until the last beat has gone by, so RUN begins with a full chain.
	// RUN leaves on stop, and STOP goes back to IDLE once enable has dropped.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= hilbertPkg::stateIdle;
			romStart <= 1'b0;
		end else begin
			romStart <= 1'b0;
			case (state)
				hilbertPkg::stateIdle: begin
					if (enable) begin
						state <= hilbertPkg::stateLoad;
						romStart <= 1'b1;
					end
				end
				hilbertPkg::stateLoad: begin
					if (coeffBeat.valid && coeffBeat.last) begin
						state <= hilbertPkg::stateRun;
					end
				end
				hilbertPkg::stateRun: begin
					if (stop) begin
						state <= hilbertPkg::stateStop;
					end
				end
				hilbertPkg::stateStop: begin
					if (!enable) begin
						state <= hilbertPkg::stateIdle;
					end
				end
				default: begin
					state <= hilbertPkg::stateIdle;
				end
			endcase
		end
	end

	assign running = (state == hilbertPkg::stateRun);

	// Each run starts from an empty history.
	assign clearHistory = (state == hilbertPkg::stateIdle);

	// Samples reach the filter only in RUN. Anything offered in another state is dropped.
	assign firIn = running ? sampleIn : '0;

	// A stop seen this cycle already counts, so the output falls silent on the same
	// edge that leaves RUN.
	assign keepRunning = running && !stop;

	// Results are registered once more on the way out, which makes the latency
	// from sampleIn three cycles.
	// Gaps and every cycle outside RUN read as all zero, and results still in the
	// filter when RUN ends are dropped.
	always_ff @(posedge clock) begin
		if (reset) begin
			analyticOut <= '0;
		end else if (keepRunning && firOut.valid) begin
			analyticOut <= firOut;
		end else begin
			analyticOut <= '0;
		end
	end

endmodule

`default_nettype wire
